// File: hdl/block_buffer.sv
////////////////////////////////////////
// ping-pong block memory
// two banks, separate write and read
// ports, read data one clock later
////////////////////////////////////////

`timescale 1ns/100ps

module block_buffer #(
	parameter int depth = rs_pkg::rs_k     // bytes kept per bank
)(
	input  logic             clk,
	input  logic             ce,           // write strobe
	input  logic             wr_bank,
	input  rs_pkg::addr_t    wr_addr,
	input  gf_pkg::gf_byte_t wr_data,
	input  logic             rd_en,
	input  logic             rd_bank,
	input  rs_pkg::addr_t    rd_addr,
	output gf_pkg::gf_byte_t rd_data
);

	gf_pkg::gf_byte_t mem [2][depth];    // [bank][byte]
	logic             wr_in_range;

	// bytes past depth (the parity) are not stored
	assign wr_in_range = (int'(wr_addr) < depth);

	// write side follows the incoming block
	always_ff @(posedge clk)
	begin
		if (ce && wr_in_range)
			mem[wr_bank][wr_addr] <= wr_data;
	end

	// read side, held between reads
	always_ff @(posedge clk)
	begin
		if (rd_en)
			rd_data <= mem[rd_bank][rd_addr];
	end

endmodule

// File: hdl/decoder_control.sv
////////////////////////////////////////
// block sequencing
// byte count, bank toggle, error flags
// and output launch with pending start
////////////////////////////////////////

`timescale 1ns/100ps

module decoder_control #(
	parameter int block_len = rs_pkg::rs_n
)(
	input  logic          clk,
	input  logic          reset,
	input  logic          ce,
	input  logic          syn_error,
	input  logic          out_done,     // output stage finished a block
	output logic          first_byte,
	output logic          wr_bank,      // bank being filled
	output rs_pkg::addr_t wr_addr,
	output logic          start,        // one clock launch pulse
	output logic          rd_bank,      // bank being read out
	output logic          bank_error    // error flag of the launched bank
);

	typedef enum logic [1:0] {
		st_idle,      // output stage free
		st_run,       // one block being sent out
		st_pend       // another block waits for out_done
	} ctrl_state_t;

	ctrl_state_t   state;
	ctrl_state_t   next_state;
	rs_pkg::addr_t byte_cnt;
	logic          block_done;   // cycle after the last byte strobe
	logic [1:0]    bank_err;     // error flag per bank
	logic          pend_bank;    // bank waiting for launch
	logic          launch_bank;
	logic          rd_bank_q;

	assign first_byte = ce && (byte_cnt == '0);
	assign wr_addr    = byte_cnt;
	assign rd_bank    = start ? launch_bank : rd_bank_q;   // new bank on the launch clock

	////////////////////////////////////////
	// input byte counter
	////////////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			byte_cnt   <= '0;
			block_done <= 1'b0;
		end
		else
		begin
			block_done <= 1'b0;
			if (ce)
			begin
				if (byte_cnt == rs_pkg::addr_t'(block_len - 1))
				begin
					byte_cnt   <= '0;
					block_done <= 1'b1;   // syndromes final next cycle
				end
				else
					byte_cnt <= byte_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// launch fsm
	////////////////////////////////////////
	always_comb
	begin
		next_state  = state;
		start       = 1'b0;
		launch_bank = wr_bank;      // bank just filled, flips at this edge
		bank_error  = syn_error;    // live result of that bank
		case (state)
			st_idle:
			begin
				if (block_done)
				begin
					start      = 1'b1;
					next_state = st_run;
				end
			end
			st_run:
			begin
				if (block_done && !out_done)
					next_state = st_pend;    // hold until the stage is free
				else if (block_done)
					start = 1'b1;            // free this very cycle
				else if (out_done)
					next_state = st_idle;
			end
			st_pend:
			begin
				launch_bank = pend_bank;
				bank_error  = bank_err[pend_bank];
				if (out_done)
				begin
					start      = 1'b1;
					next_state = st_run;
				end
			end
			default:
				next_state = st_idle;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state     <= st_idle;
			wr_bank   <= 1'b0;
			bank_err  <= '0;
			pend_bank <= 1'b0;
			rd_bank_q <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (block_done)
			begin
				bank_err[wr_bank] <= syn_error;   // record before the flip
				wr_bank           <= ~wr_bank;
			end
			if (state == st_run && next_state == st_pend)
				pend_bank <= wr_bank;
			if (start)
				rd_bank_q <= launch_bank;         // held for the whole readout
		end
	end

endmodule

// File: hdl/gf_pkg.sv
////////////////////////////////////////
// gf256 field arithmetic
// symbol type, primitive polynomial and
// multiply by a constant power of alpha
////////////////////////////////////////

package gf_pkg;

	localparam int gf_width = 8;                  // bits per symbol

	typedef logic [gf_width-1:0] gf_byte_t;       // one field element

	// x^8 + x^4 + x^3 + x^2 + 1, alpha is a root
	localparam logic [gf_width:0] gf_prim_poly = 9'h11D;

	////////////////////////////////////////
	// value * alpha^power
	////////////////////////////////////////
	// each step is one multiply by alpha: shift left and fold the carry
	// back in through the low bits of the polynomial
	// power is a constant at every call site so the loop flattens to xor gates
	function automatic gf_byte_t gf_mul_alpha_pow(
		input gf_byte_t    value,
		input int unsigned power
	);
		gf_byte_t result;
		result = value;
		for (int unsigned i = 0; i < power; i++)
		begin
			if (result[gf_width-1])
				result = (result << 1) ^ gf_prim_poly[gf_width-1:0];   // reduce
			else
				result = result << 1;
		end
		return result;
	endfunction

endpackage

// File: hdl/out_stage.sv
////////////////////////////////////////
// output stage
// reads the data bytes of one bank, one
// every out_spacing clocks, with ceo
////////////////////////////////////////

`timescale 1ns/100ps

module out_stage #(
	parameter int data_len = rs_pkg::rs_k     // bytes sent per block
)(
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  logic             bank_error,
	output logic             rd_en,
	output rs_pkg::addr_t    rd_addr,
	input  gf_pkg::gf_byte_t rd_data,
	output gf_pkg::gf_byte_t out_byte,
	output logic             ceo,
	output logic             block_error,
	output logic             valid_out,
	output logic             out_done       // one clock after the last ceo
);

	localparam int            space_w   = $clog2(rs_pkg::out_spacing);
	localparam rs_pkg::addr_t last_addr = rs_pkg::addr_t'(data_len - 1);

	logic               active;          // reads still to issue
	logic               take;            // accepted launch
	logic [space_w-1:0] space_cnt;       // clocks since the last read
	logic               err_q;           // error flag of the current block
	logic               rd_last;
	logic               rd_valid;        // rd_data holds a fresh byte
	logic               rd_valid_last;
	logic               out_last;        // aligned with the final ceo

	assign take    = start && !active;
	assign rd_last = (rd_addr == last_addr);    // parity addresses never reached
	assign rd_en   = take || (active && space_cnt == space_w'(rs_pkg::out_spacing - 1));

	////////////////////////////////////////
	// read sequencer
	////////////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			active    <= 1'b0;
			rd_addr   <= '0;
			space_cnt <= '0;
			err_q     <= 1'b0;
		end
		else
		begin
			if (take)
				err_q <= bank_error;
			if (rd_en)
			begin
				space_cnt <= '0;
				if (rd_last)
				begin
					active  <= 1'b0;
					rd_addr <= '0;          // ready for the next block
				end
				else
				begin
					active  <= 1'b1;
					rd_addr <= rd_addr + 1'b1;
				end
			end
			else if (active)
				space_cnt <= space_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// output strobes
	////////////////////////////////////////
	// read, buffer latency, output register: ceo two clocks after start
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rd_valid      <= 1'b0;
			rd_valid_last <= 1'b0;
			ceo           <= 1'b0;
			out_last      <= 1'b0;
			out_done      <= 1'b0;
			valid_out     <= 1'b0;
		end
		else
		begin
			rd_valid      <= rd_en;
			rd_valid_last <= rd_en && rd_last;
			ceo           <= rd_valid;
			out_last      <= rd_valid_last;
			out_done      <= out_last;
			if (rd_valid)
				valid_out <= 1'b1;     // rises with the first ceo
			else if (out_last)
				valid_out <= 1'b0;     // falls after the last ceo
		end
	end

	// byte and its flag, stable until the next ceo
	always_ff @(posedge clk)
	begin
		if (rd_valid)
		begin
			out_byte    <= rd_data;
			block_error <= err_q;
		end
	end

endmodule

// File: hdl/rs_block_checker.sv
////////////////////////////////////////
// rs(204,188) block checker top
// syndrome check, ping-pong buffer and
// spaced output of the data bytes
////////////////////////////////////////

`timescale 1ns/100ps

module rs_block_checker #(
	parameter int block_len     = rs_pkg::rs_n,      // received block length
	parameter int data_len      = rs_pkg::rs_k,      // data bytes sent out
	parameter int num_syndromes = rs_pkg::rs_parity
)(
	input  logic             clk,
	input  logic             reset,        // async, active high
	input  logic             ce,           // one clock per input byte
	input  gf_pkg::gf_byte_t in_byte,
	output gf_pkg::gf_byte_t out_byte,
	output logic             ceo,          // one clock per output byte
	output logic             block_error,  // block holds a nonzero syndrome
	output logic             valid_out     // first to last ceo of a block
);

	logic             first_byte;   // ce on byte 0 of a block
	logic             syn_error;
	logic             wr_bank;
	rs_pkg::addr_t    wr_addr;
	logic             start;        // launch output of one bank
	logic             rd_bank;
	logic             bank_error;
	logic             out_done;
	logic             rd_en;
	rs_pkg::addr_t    rd_addr;
	gf_pkg::gf_byte_t rd_data;

	////////////////////////////////////////
	// sequencing
	////////////////////////////////////////
	decoder_control #(
		.block_len (block_len)
	) i_decoder_control (
		.clk        (clk),
		.reset      (reset),
		.ce         (ce),
		.syn_error  (syn_error),
		.out_done   (out_done),
		.first_byte (first_byte),
		.wr_bank    (wr_bank),
		.wr_addr    (wr_addr),
		.start      (start),
		.rd_bank    (rd_bank),
		.bank_error (bank_error)
	);

	////////////////////////////////////////
	// datapaths
	////////////////////////////////////////
	syndrome_unit #(
		.num_syndromes (num_syndromes)
	) i_syndrome_unit (
		.clk        (clk),
		.reset      (reset),
		.ce         (ce),
		.first_byte (first_byte),
		.in_byte    (in_byte),
		.syn_error  (syn_error)
	);

	// only the data bytes are kept, parity falls outside depth
	block_buffer #(
		.depth (data_len)
	) i_block_buffer (
		.clk     (clk),
		.ce      (ce),
		.wr_bank (wr_bank),
		.wr_addr (wr_addr),
		.wr_data (in_byte),
		.rd_en   (rd_en),
		.rd_bank (rd_bank),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	out_stage #(
		.data_len (data_len)
	) i_out_stage (
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.bank_error  (bank_error),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.out_byte    (out_byte),
		.ceo         (ceo),
		.block_error (block_error),
		.valid_out   (valid_out),
		.out_done    (out_done)
	);

endmodule

// File: hdl/rs_pkg.sv
////////////////////////////////////////
// rs(204,188) code geometry
// block lengths, parity count, address
// width and output strobe spacing
////////////////////////////////////////

package rs_pkg;

	localparam int rs_n          = 204;    // bytes per received block
	localparam int rs_k          = 188;    // data bytes per block
	localparam int rs_parity     = 16;     // parity bytes, also the number of syndromes
	localparam int rs_addr_width = 8;      // covers 0..rs_n-1
	localparam int out_spacing   = 8;      // clocks between output strobes

	// byte index within a block
	typedef logic [rs_addr_width-1:0] addr_t;

	// one value per syndrome, s0 first
	typedef gf_pkg::gf_byte_t syndrome_array_t [rs_parity];

endpackage

// File: hdl/syndrome_unit.sv
////////////////////////////////////////
// syndrome accumulators
// s_j = r(alpha^j) by horner's rule, one
// step per strobe, plus nonzero detect
////////////////////////////////////////

`timescale 1ns/100ps

module syndrome_unit #(
	parameter int num_syndromes = rs_pkg::rs_parity
)(
	input  logic             clk,
	input  logic             reset,
	input  logic             ce,
	input  logic             first_byte,   // restart all accumulators
	input  gf_pkg::gf_byte_t in_byte,
	output logic             syn_error     // any syndrome nonzero
);

	logic [num_syndromes-1:0] syn_nonzero;   // one bit per syndrome

	////////////////////////////////////////
	// one accumulator per root alpha^j
	////////////////////////////////////////
	for (genvar j = 0; j < num_syndromes; j++)
	begin : g_syn
		gf_pkg::gf_byte_t acc;          // running value of s_j
		gf_pkg::gf_byte_t acc_scaled;   // acc * alpha^j

		// constant multiplier, pure xor network
		assign acc_scaled = gf_pkg::gf_mul_alpha_pow(acc, j);

		always_ff @(posedge clk or posedge reset)
		begin
			if (reset)
				acc <= '0;
			else if (ce)
			begin
				// highest degree coefficient arrives first
				if (first_byte)
					acc <= in_byte;                  // old block dropped
				else
					acc <= acc_scaled ^ in_byte;     // acc*alpha^j + r_i
			end
		end

		assign syn_nonzero[j] = |acc;
	end

	// valid for the whole block in the cycle after its last strobe
	assign syn_error = |syn_nonzero;

endmodule

// File: rs_block_checker.f
hdl/gf_pkg.sv
hdl/rs_pkg.sv
hdl/syndrome_unit.sv
hdl/block_buffer.sv
hdl/decoder_control.sv
hdl/out_stage.sv
hdl/rs_block_checker.sv
verif/rs_checker_monitor.sv
verif/tb_rs_block_checker.sv

// File: verif/rs_checker_monitor.sv
////////////////////////////////////////
// output checker for the rs block checker
// compares every ceo with the expected
// queue and checks strobe timing
////////////////////////////////////////

`timescale 1ns/100ps

module rs_checker_monitor #(
	parameter int data_len = rs_pkg::rs_k,          // strobes per block
	parameter int spacing  = rs_pkg::out_spacing    // clocks between strobes
)(
	input  logic             clk,
	input  logic             reset,
	input  gf_pkg::gf_byte_t out_byte,
	input  logic             ceo,
	input  logic             block_error,
	input  logic             valid_out
);

	int               error_count = 0;
	int               check_count = 0;    // strobes compared
	int               blocks_seen = 0;    // complete blocks
	int               cycle       = 0;
	int               last_ceo    = 0;    // cycle of the previous strobe
	int               byte_idx    = 0;    // position within the current block
	logic             in_block    = 1'b0;
	gf_pkg::gf_byte_t exp_byte_q [$];
	logic             exp_err_q  [$];

	// one expected output byte and its block flag
	task automatic push_expected(input gf_pkg::gf_byte_t data, input logic err);
		exp_byte_q.push_back(data);
		exp_err_q.push_back(err);
	endtask

	function automatic int pending();
		return exp_byte_q.size();
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[FAIL] %0t %s expected %0h got %0h", $time, name, expected, actual);
		error_count++;
	endtask

	////////////////////////////////////////
	// sampled at the rising edge, dut outputs are all registered
	////////////////////////////////////////
	always @(posedge clk)
	begin
		gf_pkg::gf_byte_t exp_data;
		logic             exp_err;
		cycle++;
		if (reset)
		begin
			if (ceo === 1'b1)
				report_mismatch("ceo", 0, ceo);               // must be forced low
			if (valid_out === 1'b1)
				report_mismatch("valid_out", 0, valid_out);
			exp_byte_q.delete();                              // partial blocks are lost
			exp_err_q.delete();
			byte_idx = 0;
			in_block = 1'b0;
		end
		else if (ceo !== 1'b0)
		begin
			check_count++;
			if (valid_out !== 1'b1)
				report_mismatch("valid_out", 1, valid_out);
			if (byte_idx > 0 && cycle - last_ceo != spacing)
				report_mismatch("ceo interval", spacing, cycle - last_ceo);
			last_ceo = cycle;
			if (exp_byte_q.size() == 0)
			begin
				$display("unexpected ceo at %0t with no byte left to expect", $time);
				error_count++;
			end
			else
			begin
				exp_data = exp_byte_q.pop_front();
				exp_err  = exp_err_q.pop_front();
				if (out_byte !== exp_data)
					report_mismatch("out_byte", exp_data, out_byte);
				if (block_error !== exp_err)
					report_mismatch("block_error", exp_err, block_error);
			end
			byte_idx++;
			in_block = (byte_idx < data_len);
			if (byte_idx == data_len)
			begin
				byte_idx = 0;
				blocks_seen++;
			end
		end
		else if (in_block && valid_out !== 1'b1)
			report_mismatch("valid_out", 1, valid_out);   // gap inside a block
		else if (!in_block && valid_out !== 1'b0)
			report_mismatch("valid_out", 0, valid_out);   // high outside a block
	end

endmodule

// File: verif/tb_rs_block_checker.sv
////////////////////////////////////////
// testbench for the rs(204,188) checker
// random codewords, error injection,
// gaps and a reset in mid block
////////////////////////////////////////

`timescale 1ns/100ps

module tb_rs_block_checker;

	localparam int n_par = rs_pkg::rs_parity;

	logic             clk     = 1'b0;
	logic             reset   = 1'b1;
	logic             ce      = 1'b0;
	gf_pkg::gf_byte_t in_byte = '0;
	gf_pkg::gf_byte_t out_byte;
	logic             ceo;
	logic             block_error;
	logic             valid_out;

	integer           seed = 32'ha8f3_ebbd;
	gf_pkg::gf_byte_t gen   [n_par+1];        // generator poly, gen[n_par] = 1
	gf_pkg::gf_byte_t block [rs_pkg::rs_n];   // block being sent, index 0 first

	always #4 clk = ~clk;

	rs_block_checker i_rs_block_checker (
		.clk         (clk),
		.reset       (reset),
		.ce          (ce),
		.in_byte     (in_byte),
		.out_byte    (out_byte),
		.ceo         (ceo),
		.block_error (block_error),
		.valid_out   (valid_out)
	);

	rs_checker_monitor #(
		.data_len (rs_pkg::rs_k),
		.spacing  (rs_pkg::out_spacing)
	) i_monitor (
		.clk         (clk),
		.reset       (reset),
		.out_byte    (out_byte),
		.ceo         (ceo),
		.block_error (block_error),
		.valid_out   (valid_out)
	);

	////////////////////////////////////////
	// gf(256) model and rs encoder
	////////////////////////////////////////
	// general multiply, shift and add, reduce by x^8+x^4+x^3+x^2+1
	function automatic gf_pkg::gf_byte_t gf_mul(input gf_pkg::gf_byte_t a,
		input gf_pkg::gf_byte_t b);
		gf_pkg::gf_byte_t p;
		gf_pkg::gf_byte_t x;
		p = '0;
		x = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				p = p ^ x;
			x = x[7] ? ((x << 1) ^ 8'h1d) : (x << 1);
		end
		return p;
	endfunction

	// g(x) = product of (x + alpha^i), i = 0..15
	task automatic build_generator();
		gf_pkg::gf_byte_t root;
		root   = 8'h01;
		gen[0] = 8'h01;
		for (int i = 1; i <= n_par; i++)
			gen[i] = '0;
		for (int r = 0; r < n_par; r++)
		begin
			for (int j = n_par; j > 0; j--)
				gen[j] = gen[j-1] ^ gf_mul(gen[j], root);
			gen[0] = gf_mul(gen[0], root);
			root   = gf_mul(root, 8'h02);     // next power of alpha
		end
	endtask

	// systematic codeword by lfsr division, then optional corruption
	task automatic make_block(input bit corrupt, output bit hit);
		gf_pkg::gf_byte_t par   [n_par];
		gf_pkg::gf_byte_t clean [rs_pkg::rs_n];
		gf_pkg::gf_byte_t fb;
		int               n_err;
		int               pos;
		for (int i = 0; i < n_par; i++)
			par[i] = '0;
		for (int i = 0; i < rs_pkg::rs_k; i++)
		begin
			block[i] = 8'($random(seed));
			fb       = block[i] ^ par[n_par-1];
			for (int j = n_par - 1; j > 0; j--)
				par[j] = par[j-1] ^ gf_mul(fb, gen[j]);
			par[0] = gf_mul(fb, gen[0]);
		end
		for (int j = 0; j < n_par; j++)
			block[rs_pkg::rs_k + j] = par[n_par-1-j];   // highest degree parity first
		clean = block;
		if (corrupt)
		begin
			n_err = 1 + ($unsigned($random(seed)) % 8);  // within the code's reach
			for (int e = 0; e < n_err; e++)
			begin
				pos        = $unsigned($random(seed)) % rs_pkg::rs_n;
				block[pos] = block[pos] ^ 8'(1 + ($unsigned($random(seed)) % 255));
			end
		end
		hit = 1'b0;
		for (int i = 0; i < rs_pkg::rs_n; i++)
			if (block[i] != clean[i])
				hit = 1'b1;                           // two hits on one byte may cancel
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	// strobes out_spacing clocks apart plus 0..extra_max more
	task automatic send_bytes(input int count, input int extra_max);
		int extra;
		for (int i = 0; i < count; i++)
		begin
			@(negedge clk);
			ce      = 1'b1;
			in_byte = block[i];
			@(negedge clk);
			ce    = 1'b0;
			extra = (extra_max > 0) ? $unsigned($random(seed)) % (extra_max + 1) : 0;
			repeat (rs_pkg::out_spacing - 2 + extra) @(negedge clk);
		end
	endtask

	task automatic run_block(input bit corrupt, input int extra_max);
		bit hit;
		make_block(corrupt, hit);
		for (int i = 0; i < rs_pkg::rs_k; i++)
			i_monitor.push_expected(block[i], hit);   // received data, no correction
		send_bytes(rs_pkg::rs_n, extra_max);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (i_monitor.pending() != 0 || i_monitor.in_block)
		begin
			@(negedge clk);
			waited++;
			if (waited > 2 * rs_pkg::rs_n * rs_pkg::out_spacing)
			begin
				$display("timeout while waiting for the queued output bytes");
				$display("TEST FAIL");
				$finish;
			end
		end
	endtask

	initial
	begin
		bit hit;
		build_generator();
		repeat (2) @(negedge clk);
		reset = 1'b0;
		// back to back at the minimum spacing
		run_block(1'b0, 0);
		run_block(1'b1, 0);
		for (int b = 0; b < 4; b++)
			run_block(($unsigned($random(seed)) % 3) == 0, 0);
		// longer random gaps
		for (int b = 0; b < 3; b++)
			run_block(($unsigned($random(seed)) % 2) == 0, 5);
		// reset in mid block while the previous block is still going out
		run_block(1'b1, 0);
		make_block(1'b0, hit);
		send_bytes(rs_pkg::rs_n / 2, 0);
		reset = 1'b1;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		run_block(1'b0, 0);
		run_block(1'b1, 2);
		wait_drain();
		repeat (4 * rs_pkg::out_spacing) @(negedge clk);   // room for a stray strobe
		$display("strobes checked %0d, blocks %0d, errors %0d",
			i_monitor.check_count, i_monitor.blocks_seen, i_monitor.error_count);
		if (i_monitor.error_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule
